// File: hw/memStagePkg.sv
`default_nettype none

package memStagePkg;

    localparam int dataWidth = 32;
    localparam int memWords  = 64;  // data memory depth in words

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [4:0]           regAddr_t;
    typedef logic [4:0]           cp0Addr_t;
    typedef logic [4:0]           excCode_t;
    typedef logic [5:0]           intVec_t;   // hardware interrupt lines

    // cp0 register numbers
    localparam cp0Addr_t cp0BadVAddr = 5'd8;
    localparam cp0Addr_t cp0Status   = 5'd12;
    localparam cp0Addr_t cp0Cause    = 5'd13;
    localparam cp0Addr_t cp0Epc      = 5'd14;

    // Cause.ExcCode values
    localparam excCode_t excInt  = 5'd0;
    localparam excCode_t excAdEL = 5'd4;
    localparam excCode_t excAdES = 5'd5;
    localparam excCode_t excSys  = 5'd8;
    localparam excCode_t excBp   = 5'd9;
    localparam excCode_t excRI   = 5'd10;
    localparam excCode_t excOv   = 5'd12;

    typedef enum logic [2:0] {loadNone, loadB, loadBU, loadH, loadHU, loadW} loadKind_e;
    typedef enum logic [1:0] {storeNone, storeB, storeH, storeW} storeKind_e;
    typedef enum logic [1:0] {selAlu, selMem, selCp0} wbSel_e;
    typedef enum logic [1:0] {trapNone, trapException, trapEret} trapKind_e;

    // raised before the memory stage
    typedef struct packed {
        logic fetchAdEL;
        logic reserved;
        logic overflow;
        logic syscall;
        logic breakpoint;
        logic eret;
    } exceptFlags_t;

    typedef struct packed {
        word_t        pc;
        word_t        aluOut;
        word_t        storeData;
        regAddr_t     dst;
        logic         regWrite;
        loadKind_e    loadKind;
        storeKind_e   storeKind;
        wbSel_e       wbSel;
        logic         cp0Write;     // mtc0
        cp0Addr_t     cp0Addr;      // mtc0/mfc0 register number
        logic         isBranch;
        exceptFlags_t exceptFlags;
    } exeMemBundle_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        regAddr_t dst;
        logic     regWrite;
    } memWbBundle_t;

    typedef struct packed {
        logic [7:0] im;
        logic       ie;
        logic       exl;
        logic [7:0] ipPending;  // Cause.IP, hw and sw
    } cp0Status_t;

    typedef struct packed {
        logic     take;         // exception, not eret
        logic     eret;
        excCode_t code;
        word_t    pc;
        word_t    badAddr;
        logic     hasBadAddr;
        logic     inDelaySlot;
    } trapEvent_t;

endpackage

`default_nettype wire

// File: hw/memStageReg.sv
`default_nettype none

module memStageReg (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       memFlush,
    input  logic                       memWr,
    input  memStagePkg::exeMemBundle_t exeIn,
    output memStagePkg::exeMemBundle_t memPipe,
    output logic                       inDelaySlot
);

    // an all-zero bundle is a bubble with no write, store or flags
    always_ff @(posedge clk) begin
        if (reset || memFlush) begin
            memPipe <= '0;
        end else if (memWr) begin
            memPipe <= exeIn;
        end
    end

    // remembers whether the instruction being replaced was a branch,
    // so the incoming one sits in its delay slot
    always_ff @(posedge clk) begin
        if (reset || memFlush) begin
            inDelaySlot <= 1'b0;    // handler entry is never a delay slot
        end else if (memWr) begin
            inDelaySlot <= memPipe.isBranch;
        end
    end

endmodule

`default_nettype wire

// File: hw/dataMemPort.sv
`default_nettype none

module dataMemPort (
    input  logic                    clk,
    input  memStagePkg::word_t      addr,
    input  memStagePkg::word_t      storeData,
    input  memStagePkg::loadKind_e  loadKind,
    input  memStagePkg::storeKind_e storeKind,
    input  logic                    storeCommit,
    output memStagePkg::word_t      loadData,
    output logic                    loadAddrError,
    output logic                    storeAddrError
);
    import memStagePkg::*;

    word_t mem [memWords];

    logic [$clog2(memWords)-1:0] wordIdx;
    word_t      rdWord;
    logic [7:0] rdByte;
    logic [15:0] rdHalf;
    logic [3:0] byteEn;
    word_t      wrWord;

    assign wordIdx = addr[$clog2(memWords)+1:2];

    // alignment: words on 4, halves on 2
    assign loadAddrError = (loadKind == loadW && addr[1:0] != 2'b00) ||
                           ((loadKind == loadH || loadKind == loadHU) && addr[0]);
    assign storeAddrError = (storeKind == storeW && addr[1:0] != 2'b00) ||
                            (storeKind == storeH && addr[0]);

    // lane enables and replicated write data
    always_comb begin
        byteEn = 4'b0000;
        wrWord = storeData;
        case (storeKind)
            storeB: begin
                byteEn = 4'b0001 << addr[1:0];
                wrWord = {4{storeData[7:0]}};
            end
            storeH: begin
                byteEn = addr[1] ? 4'b1100 : 4'b0011;
                wrWord = {2{storeData[15:0]}};
            end
            storeW: begin
                byteEn = 4'b1111;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (storeCommit) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEn[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= wrWord[8*lane +: 8];
                end
            end
        end
    end

    // combinational read
    assign rdWord = mem[wordIdx];
    assign rdByte = rdWord[8*addr[1:0] +: 8];
    assign rdHalf = addr[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        case (loadKind)
            loadB:   loadData = {{24{rdByte[7]}}, rdByte};
            loadBU:  loadData = {24'b0, rdByte};
            loadH:   loadData = {{16{rdHalf[15]}}, rdHalf};
            loadHU:  loadData = {16'b0, rdHalf};
            loadW:   loadData = rdWord;
            default: loadData = '0;
        endcase
    end

    // commit comes from the top after trap ranking
    assert property (@(posedge clk) !(storeCommit && storeAddrError))
        else $error("misaligned store committed to memory");

endmodule

`default_nettype wire

// File: hw/exceptionUnit.sv
`default_nettype none

module exceptionUnit (
    input  memStagePkg::exeMemBundle_t memPipe,
    input  logic                       inDelaySlot,
    input  logic                       loadAddrError,
    input  logic                       storeAddrError,
    input  memStagePkg::cp0Status_t    status,
    output memStagePkg::trapEvent_t    trap,
    output logic                       regWriteFinal,
    output logic                       idFlush,
    output logic                       exeFlush,
    output logic                       memFlushOut,
    output memStagePkg::trapKind_e     trapKind
);
    import memStagePkg::*;

    logic     valid;
    logic     intPending;
    logic     take;
    logic     doEret;
    excCode_t code;
    word_t    badAddr;
    logic     hasBadAddr;

    assign valid      = (memPipe != '0);   // bubbles never trap
    assign intPending = |(status.ipPending & status.im) && status.ie && !status.exl;

    // highest ranked cause wins
    always_comb begin
        take       = 1'b0;
        code       = excInt;
        badAddr    = '0;
        hasBadAddr = 1'b0;
        if (valid) begin
            take = 1'b1;
            if (intPending) begin
                code = excInt;
            end else if (memPipe.exceptFlags.fetchAdEL) begin
                code       = excAdEL;
                badAddr    = memPipe.pc;
                hasBadAddr = 1'b1;
            end else if (memPipe.exceptFlags.reserved) begin
                code = excRI;
            end else if (memPipe.exceptFlags.overflow) begin
                code = excOv;
            end else if (memPipe.exceptFlags.syscall) begin
                code = excSys;
            end else if (memPipe.exceptFlags.breakpoint) begin
                code = excBp;
            end else if (loadAddrError || storeAddrError) begin
                code       = loadAddrError ? excAdEL : excAdES;
                badAddr    = memPipe.aluOut;   // data address
                hasBadAddr = 1'b1;
            end else begin
                take = 1'b0;
            end
        end
    end

    assign doEret = valid && !take && memPipe.exceptFlags.eret;

    assign trap = '{take: take, eret: doEret, code: code, pc: memPipe.pc,
                    badAddr: badAddr, hasBadAddr: hasBadAddr, inDelaySlot: inDelaySlot};

    always_comb begin
        if (take) begin
            trapKind = trapException;
        end else if (doEret) begin
            trapKind = trapEret;
        end else begin
            trapKind = trapNone;
        end
    end

    assign regWriteFinal = memPipe.regWrite && !take && !doEret;
    assign idFlush       = take || doEret;
    assign exeFlush      = take || doEret;
    assign memFlushOut   = take || doEret;

    always_comb begin
        assert final (valid || trapKind == trapNone)
            else $error("trap raised on a bubble");
    end

endmodule

`default_nettype wire

// File: hw/cp0Regs.sv
`default_nettype none

module cp0Regs (
    input  logic                    clk,
    input  logic                    reset,
    input  memStagePkg::intVec_t    interrupt,
    input  logic                    memWr,
    input  memStagePkg::cp0Addr_t   rdAddr,
    input  logic                    wrEnable,
    input  memStagePkg::word_t      wrData,
    input  memStagePkg::trapEvent_t trap,
    output memStagePkg::word_t      rdData,
    output memStagePkg::cp0Status_t status,
    output memStagePkg::word_t      epc
);
    import memStagePkg::*;

    // Status
    logic [7:0] statusIm;
    logic       statusExl;
    logic       statusIe;
    // Cause
    logic       causeBd;
    logic [5:0] causeIpHw;  // IP7..2
    logic [1:0] causeIpSw;  // IP1..0
    excCode_t   causeExc;
    word_t      epcReg;
    word_t      badVAddr;

    logic mtc0Go;

    // mtc0 loses to any trap in the same cycle
    assign mtc0Go = wrEnable && memWr && !trap.take && !trap.eret;

    always_ff @(posedge clk) begin
        if (reset) begin
            causeIpHw <= '0;
        end else begin
            causeIpHw <= interrupt;     // sampled every cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            statusIm  <= '0;
            statusExl <= 1'b1;
            statusIe  <= 1'b0;
            causeBd   <= 1'b0;
            causeIpSw <= '0;
            causeExc  <= excInt;
            epcReg    <= '0;
            badVAddr  <= '0;
        end else if (memWr) begin
            if (trap.take) begin
                statusExl <= 1'b1;
                causeBd   <= trap.inDelaySlot;
                causeExc  <= trap.code;
                // restart at the branch when in a delay slot
                epcReg    <= trap.inDelaySlot ? trap.pc - 32'd4 : trap.pc;
                if (trap.hasBadAddr) begin
                    badVAddr <= trap.badAddr;
                end
            end else if (trap.eret) begin
                statusExl <= 1'b0;
            end else if (mtc0Go) begin
                case (rdAddr)
                    cp0Status: begin
                        statusIm  <= wrData[15:8];
                        statusExl <= wrData[1];
                        statusIe  <= wrData[0];
                    end
                    cp0Cause: causeIpSw <= wrData[9:8];
                    cp0Epc:   epcReg    <= wrData;
                    default: ;  // BadVAddr is read only
                endcase
            end
        end
    end

    // mfc0 read, same register number port as mtc0
    always_comb begin
        case (rdAddr)
            cp0Status:   rdData = {16'b0, statusIm, 6'b0, statusExl, statusIe};
            cp0Cause:    rdData = {causeBd, 15'b0, causeIpHw, causeIpSw, 1'b0, causeExc, 2'b0};
            cp0Epc:      rdData = epcReg;
            cp0BadVAddr: rdData = badVAddr;
            default:     rdData = '0;
        endcase
    end

    assign status = '{im: statusIm, ie: statusIe, exl: statusExl,
                      ipPending: {causeIpHw, causeIpSw}};
    assign epc    = epcReg;

endmodule

`default_nettype wire

// File: hw/memStage.sv
`default_nettype none

module memStage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       memFlush,
    input  logic                       memWr,
    input  memStagePkg::intVec_t       interrupt,
    input  memStagePkg::exeMemBundle_t exeIn,
    output memStagePkg::memWbBundle_t  wbOut,
    output memStagePkg::word_t         forwardData,
    output logic                       idFlush,
    output logic                       exeFlush,
    output logic                       memFlushOut,
    output memStagePkg::trapKind_e     trapKind,
    output memStagePkg::word_t         epc
);
    import memStagePkg::*;

    exeMemBundle_t memPipe;
    logic          inDelaySlot;
    word_t         loadData;
    logic          loadAddrError;
    logic          storeAddrError;
    logic          storeCommit;
    cp0Status_t    cp0Status;
    trapEvent_t    trap;
    logic          regWriteFinal;
    word_t         cp0RdData;
    word_t         result;

    memStageReg uMemStageReg (
        .clk         (clk),
        .reset       (reset),
        .memFlush    (memFlush),
        .memWr       (memWr),
        .exeIn       (exeIn),
        .memPipe     (memPipe),
        .inDelaySlot (inDelaySlot)
    );

    // store only when nothing traps and the stage is not stalled
    assign storeCommit = (memPipe.storeKind != storeNone) && (trapKind == trapNone) && memWr;

    dataMemPort uDataMemPort (
        .clk            (clk),
        .addr           (memPipe.aluOut),
        .storeData      (memPipe.storeData),
        .loadKind       (memPipe.loadKind),
        .storeKind      (memPipe.storeKind),
        .storeCommit    (storeCommit),
        .loadData       (loadData),
        .loadAddrError  (loadAddrError),
        .storeAddrError (storeAddrError)
    );

    exceptionUnit uExceptionUnit (
        .memPipe        (memPipe),
        .inDelaySlot    (inDelaySlot),
        .loadAddrError  (loadAddrError),
        .storeAddrError (storeAddrError),
        .status         (cp0Status),
        .trap           (trap),
        .regWriteFinal  (regWriteFinal),
        .idFlush        (idFlush),
        .exeFlush       (exeFlush),
        .memFlushOut    (memFlushOut),
        .trapKind       (trapKind)
    );

    cp0Regs uCp0Regs (
        .clk       (clk),
        .reset     (reset),
        .interrupt (interrupt),
        .memWr     (memWr),
        .rdAddr    (memPipe.cp0Addr),
        .wrEnable  (memPipe.cp0Write),
        .wrData    (memPipe.aluOut),    // mtc0 operand comes through the alu
        .trap      (trap),
        .rdData    (cp0RdData),
        .status    (cp0Status),
        .epc       (epc)
    );

    always_comb begin
        case (memPipe.wbSel)
            selMem:  result = loadData;
            selCp0:  result = cp0RdData;   // mfc0
            default: result = memPipe.aluOut;
        endcase
    end

    assign forwardData = result;    // bypass to execute
    assign wbOut = '{pc: memPipe.pc, result: result, dst: memPipe.dst, regWrite: regWriteFinal};

endmodule

`default_nettype wire

// File: tests/memStageTb.sv
`default_nettype none

module memStageTb;
    timeunit 1ns;
    timeprecision 1ps;
    import memStagePkg::*;

    localparam int maxCycles = 200;    // far more than the pattern file holds

    // expected outputs of one pattern line
    typedef struct packed {
        word_t      result;
        logic       regWrite;
        regAddr_t   dst;
        trapKind_e  trapKind;
        logic [2:0] flush;      // idFlush, exeFlush, memFlushOut
        word_t      epc;
        word_t      pc;
    } expect_t;

    logic          clk;
    logic          reset;
    logic          memFlush;
    logic          memWr;
    intVec_t       interrupt;
    exeMemBundle_t exeIn;
    memWbBundle_t  wbOut;
    word_t         forwardData;
    logic          idFlush;
    logic          exeFlush;
    logic          memFlushOut;
    trapKind_e     trapKind;
    word_t         epc;

    memStage UUT (
        .clk         (clk),
        .reset       (reset),
        .memFlush    (memFlush),
        .memWr       (memWr),
        .interrupt   (interrupt),
        .exeIn       (exeIn),
        .wbOut       (wbOut),
        .forwardData (forwardData),
        .idFlush     (idFlush),
        .exeFlush    (exeFlush),
        .memFlushOut (memFlushOut),
        .trapKind    (trapKind),
        .epc         (epc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compareField(input string tag, input string what,
                                input word_t expVal, input word_t actVal);
        assert (actVal === expVal)
            else begin
                $display("Fail %s %s: expected %h actual %h", tag, what, expVal, actVal);
                $display("sim failed");
                $fatal(1, "output mismatch");
            end
    endtask

    task automatic checkOutputs(input string tag, input expect_t exp);
        compareField(tag, "result", exp.result, wbOut.result);
        compareField(tag, "forwardData", exp.result, forwardData);
        compareField(tag, "regWrite", 32'(exp.regWrite), 32'(wbOut.regWrite));
        compareField(tag, "dst", 32'(exp.dst), 32'(wbOut.dst));
        compareField(tag, "pc", exp.pc, wbOut.pc);
        compareField(tag, "trapKind", 32'(exp.trapKind), 32'(trapKind));
        compareField(tag, "flush", 32'(exp.flush), {29'b0, idFlush, exeFlush, memFlushOut});
        compareField(tag, "epc", exp.epc, epc);
    endtask

    // fetches the next non-comment line and clears got at end of file
    task automatic readPattern(input int fd, output bit got, output string tag,
                               output exeMemBundle_t bundle, output intVec_t intr,
                               output logic flushIn, output logic wrIn, output expect_t exp);
        string       line;
        int          count;
        logic [31:0] pc, alu, sdata, dst, rw, lk, sk, ws, cw, ca, br, fl, irq, mf, mw;
        logic [31:0] eRes, eRw, eDst, eTk, eFl, eEpc;
        got     = 1'b0;
        tag     = "";
        bundle  = '0;
        intr    = '0;
        flushIn = 1'b0;
        wrIn    = 1'b1;
        exp     = '0;
        while (!got && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                count = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tag, pc, alu, sdata, dst, rw, lk, sk, ws, cw, ca, br, fl, irq, mf, mw,
                    eRes, eRw, eDst, eTk, eFl, eEpc);
                if (count != 22) begin
                    $display("malformed line in pattern file: %s", line);
                    $display("sim failed");
                    $fatal(1, "bad pattern file");
                end
                bundle.pc          = pc;
                bundle.aluOut      = alu;
                bundle.storeData   = sdata;
                bundle.dst         = dst[4:0];
                bundle.regWrite    = rw[0];
                bundle.loadKind    = loadKind_e'(lk[2:0]);
                bundle.storeKind   = storeKind_e'(sk[1:0]);
                bundle.wbSel       = wbSel_e'(ws[1:0]);
                bundle.cp0Write    = cw[0];
                bundle.cp0Addr     = ca[4:0];
                bundle.isBranch    = br[0];
                bundle.exceptFlags = exceptFlags_t'(fl[5:0]);
                intr               = irq[5:0];
                flushIn            = mf[0];
                wrIn               = mw[0];
                exp.result         = eRes;
                exp.regWrite       = eRw[0];
                exp.dst            = eDst[4:0];
                exp.trapKind       = trapKind_e'(eTk[1:0]);
                exp.flush          = eFl[2:0];
                exp.epc            = eEpc;
                got                = 1'b1;
            end
        end
    endtask

    initial begin
        int            fd;
        int            cycles;
        bit            got;
        bit            havePrev;
        string         tag;
        string         prevTag;
        exeMemBundle_t bundle;
        intVec_t       intr;
        logic          flushIn;
        logic          wrIn;
        expect_t       exp;
        expect_t       prevExp;
        word_t         heldPc;

        reset     = 1'b1;
        memFlush  = 1'b0;
        memWr     = 1'b0;
        interrupt = '0;
        exeIn     = '0;

        fd = $fopen("tests/memStagePatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/memStagePatterns.txt");
            $display("sim failed");
            $fatal(1, "no stimulus");
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        got      = 1'b1;
        havePrev = 1'b0;
        cycles   = 0;
        heldPc   = '0;      // reset leaves a bubble in the stage
        while (got && cycles < maxCycles) begin
            @(posedge clk);
            readPattern(fd, got, tag, bundle, intr, flushIn, wrIn, exp);
            // pc the stage register holds after the next edge
            if (flushIn) begin
                exp.pc = '0;
            end else if (wrIn) begin
                exp.pc = bundle.pc;
            end else begin
                exp.pc = heldPc;
            end
            heldPc = exp.pc;
            exeIn     <= bundle;    // a bubble once the file is used up
            interrupt <= intr;
            memFlush  <= flushIn;
            memWr     <= wrIn;
            // outputs now belong to the line driven one edge earlier
            @(negedge clk);
            if (havePrev) begin
                checkOutputs(prevTag, prevExp);
            end
            prevTag  = tag;
            prevExp  = exp;
            havePrev = got;
            cycles++;
        end
        $fclose(fd);

        if (got) begin
            $display("pattern file did not end within %0d cycles", maxCycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/memStagePatterns.txt
# tag pc alu sdata dst rw ld st wb cw ca br flags int flush wr  (all hex)
# then expected: result regWrite dst trapKind flush(id,exe,mem) epc
stW16      100 40 8899aabb 0 0 0 3 0 0 0 0 0 0 0 1  40 0 0 0 0 0
stW17      104 44 11223344 0 0 0 3 0 0 0 0 0 0 0 1  44 0 0 0 0 0
stB17      108 45 f0 0 0 0 1 0 0 0 0 0 0 0 1  45 0 0 0 0 0
stH16      10c 42 8001 0 0 0 2 0 0 0 0 0 0 0 1  42 0 0 0 0 0
ldW        110 40 0 2 1 5 0 1 0 0 0 0 0 0 1  8001aabb 1 2 0 0 0
ldB        114 41 0 3 1 1 0 1 0 0 0 0 0 0 1  ffffffaa 1 3 0 0 0
ldBU       118 41 0 4 1 2 0 1 0 0 0 0 0 0 1  aa 1 4 0 0 0
ldH        11c 42 0 5 1 3 0 1 0 0 0 0 0 0 1  ffff8001 1 5 0 0 0
ldHU       120 42 0 6 1 4 0 1 0 0 0 0 0 0 1  8001 1 6 0 0 0
ldBPos     124 47 0 7 1 1 0 1 0 0 0 0 0 0 1  11 1 7 0 0 0
ldHNeg     128 44 0 8 1 3 0 1 0 0 0 0 0 0 1  fffff044 1 8 0 0 0
mtc0Epc    12c 1234 0 0 0 0 0 0 1 e 0 0 0 0 1  1234 0 0 0 0 0
mfc0Epc    130 0 0 9 1 0 0 2 0 e 0 0 0 0 1  1234 1 9 0 0 1234
aluFwd     134 cafe0001 0 a 1 0 0 0 0 0 0 0 0 0 1  cafe0001 1 a 0 0 1234
mtc0Status 138 401 0 0 0 0 0 0 1 c 0 0 0 0 1  401 0 0 0 0 1234
syscall    13c 55 0 b 1 0 0 0 0 0 0 4 0 0 1  55 0 b 1 7 1234
mfc0Cause  180 0 0 c 1 0 0 2 0 d 0 0 0 0 1  20 1 c 0 0 13c
stMisalign 184 42 deadbeef 0 0 0 3 0 0 0 0 0 0 0 1  42 0 0 1 7 13c
ldUnchang  188 40 0 d 1 5 0 1 0 0 0 0 0 0 1  8001aabb 1 d 0 0 184
mfc0BadVA  18c 0 0 e 1 0 0 2 0 8 0 0 0 0 1  42 1 e 0 0 184
branch     200 210 0 0 0 0 0 0 0 0 1 0 0 0 1  210 0 0 0 0 184
slotOvf    204 77 0 f 1 0 0 0 0 0 0 8 0 0 1  77 0 f 1 7 184
mfc0CauseBd 180 0 0 10 1 0 0 2 0 d 0 0 0 0 1  80000030 1 10 0 0 200
eret       1a0 1 0 0 0 0 0 0 0 0 0 1 0 0 1  1 0 0 2 7 200
intMasked  300 99 0 11 1 0 0 0 0 0 0 0 2 0 1  99 1 11 0 0 200
intTaken   304 aa 0 12 1 0 0 0 0 0 0 0 1 0 1  aa 0 12 1 7 200
intInExl   180 5 0 13 1 0 0 0 0 0 0 0 1 0 1  5 1 13 0 0 304
eretPend   184 1 0 0 0 0 0 0 0 0 0 1 1 0 1  1 0 0 2 7 304
intAgain   308 6 0 14 1 0 0 0 0 0 0 0 1 0 1  6 0 14 1 7 304
flushSys   400 123 0 15 1 0 0 0 0 0 0 4 0 1 1  0 0 0 0 0 308
stallStore 404 48 01020304 0 0 0 3 0 0 0 0 0 0 0 1  48 0 0 0 0 308
stallHold  408 48 0 16 1 5 0 1 0 0 0 0 0 0 0  48 0 0 0 0 308
stallLoad  408 48 0 16 1 5 0 1 0 0 0 0 0 0 1  1020304 1 16 0 0 308
afterStall 40c 7 0 17 1 0 0 0 0 0 0 0 0 0 1  7 1 17 0 0 308

// File: memStage.f
hw/memStagePkg.sv
hw/memStageReg.sv
hw/dataMemPort.sv
hw/exceptionUnit.sv
hw/cp0Regs.sv
hw/memStage.sv
tests/memStageTb.sv

// File: Makefile
# Verilator build and run for the memory-access stage testbench

.PHONY: all run lint clean

all: run

obj_dir/VmemStageTb: memStage.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module memStageTb -f memStage.f

run: obj_dir/VmemStageTb
	@out=$$(./obj_dir/VmemStageTb); echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module memStageTb -f memStage.f

clean:
	rm -rf obj_dir
